/* design/axil_read_channel.sv */
//*********************************************************************
// AXI-Lite read channel with AR handshake and held R response.
//*********************************************************************
`timescale 1ns/10ps

module axil_read_channel (
  input  logic                  s_axi_aclk,
  input  logic                  rst_n,
  // AR channel.
  input  reg_io_pkg::axi_addr_t s_axi_araddr,
  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  // R channel.
  input  logic                  s_axi_rready,
  output logic                  s_axi_rvalid,
  output reg_io_pkg::reg_word_t s_axi_rdata,
  output reg_io_pkg::axi_resp_t s_axi_rresp,
  // Toward the register bank.
  output reg_io_pkg::axi_addr_t rd_addr,
  input  reg_io_pkg::rd_rsp_t   rd_rsp
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ACCEPT,
    RD_RESPOND
  } rd_state_t;

  rd_state_t state_q;
  rd_state_t state_d;

  //*******************************************************************
  // State machine
  //*******************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (s_axi_arvalid) begin
          state_d = RD_ACCEPT;
        end
      end
      RD_ACCEPT: begin
        state_d = RD_RESPOND;
      end
      // No new address until the data is taken.
      RD_RESPOND: begin
        if (s_axi_rready) begin
          state_d = RD_IDLE;
        end
      end
      default: begin
        state_d = RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //*******************************************************************
  // Data path
  //*******************************************************************

  // Master holds araddr through accept, so the bank sees it directly.
  assign rd_addr = s_axi_araddr;

  // Answer is frozen on the accept edge and held under back-pressure.
  always_ff @(posedge s_axi_aclk) begin
    if (state_q == RD_ACCEPT) begin
      s_axi_rdata <= rd_rsp.data;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_rresp <= reg_io_pkg::RESP_OKAY;
    end else if (state_q == RD_ACCEPT) begin
      s_axi_rresp <= rd_rsp.resp;
    end
  end

  assign s_axi_arready = (state_q == RD_ACCEPT);
  assign s_axi_rvalid  = (state_q == RD_RESPOND);

endmodule

/* design/axil_write_channel.sv */
//*********************************************************************
// AXI-Lite write channel.
// Joins AW and W into one write strobe and returns the B response.
//*********************************************************************
`timescale 1ns/10ps

module axil_write_channel (
  input  logic                  s_axi_aclk,
  input  logic                  rst_n,
  // AW channel.
  input  reg_io_pkg::axi_addr_t s_axi_awaddr,
  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  // W channel.
  input  reg_io_pkg::reg_word_t  s_axi_wdata,
  input  reg_io_pkg::byte_strb_t s_axi_wstrb,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,
  // B channel.
  input  logic                  s_axi_bready,
  output logic                  s_axi_bvalid,
  output reg_io_pkg::axi_resp_t s_axi_bresp,
  // Toward the register bank.
  output logic                  wr_en,
  output reg_io_pkg::wr_req_t   wr_req,
  input  reg_io_pkg::axi_resp_t wr_resp
);

  // Idle waits for both request channels.
  // Accept is the single handshake cycle.
  // Respond holds B until the master takes it.
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ACCEPT,
    WR_RESPOND
  } wr_state_t;

  wr_state_t state_q;
  wr_state_t state_d;

  // Both halves of the write are present.
  logic req_seen;

  assign req_seen = s_axi_awvalid && s_axi_wvalid;

  //*******************************************************************
  // State machine
  //*******************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: begin
        if (req_seen) begin
          state_d = WR_ACCEPT;
        end
      end
      // Accept always lasts exactly one cycle.
      WR_ACCEPT: begin
        state_d = WR_RESPOND;
      end
      WR_RESPOND: begin
        if (s_axi_bready) begin
          state_d = WR_IDLE;
        end
      end
      default: begin
        state_d = WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //*******************************************************************
  // Request capture and response
  //*******************************************************************

  // Master holds AW and W stable until the handshake.
  // So the capture made in idle is still valid during accept.
  always_ff @(posedge s_axi_aclk) begin
    if (state_q == WR_IDLE && req_seen) begin
      wr_req.addr <= s_axi_awaddr;
      wr_req.data <= s_axi_wdata;
      wr_req.strb <= s_axi_wstrb;
    end
  end

  // Bank answers during the accept cycle.
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_bresp <= reg_io_pkg::RESP_OKAY;
    end else if (state_q == WR_ACCEPT) begin
      s_axi_bresp <= wr_resp;
    end
  end

  // Both readies and the bank strobe share the accept cycle.
  assign s_axi_awready = (state_q == WR_ACCEPT);
  assign s_axi_wready  = (state_q == WR_ACCEPT);
  assign wr_en         = (state_q == WR_ACCEPT);
  assign s_axi_bvalid  = (state_q == WR_RESPOND);

endmodule

/* design/reg_bank.sv */
//*********************************************************************
// Register bank with address decode, byte merge and response choice.
//*********************************************************************
`timescale 1ns/10ps

module reg_bank #(
  parameter bit                    USE_WSTRB = 1'b0,
  parameter reg_io_pkg::axi_addr_t BASEADDR  = 32'hFFFF_FFFF,
  parameter reg_io_pkg::axi_addr_t HIGHADDR  = 32'h0000_0000
) (
  input  logic                  s_axi_aclk,
  input  logic                  rst_n,
  // Write side.
  input  logic                  wr_en,
  input  reg_io_pkg::wr_req_t   wr_req,
  output reg_io_pkg::axi_resp_t wr_resp,
  // Read side.
  input  reg_io_pkg::axi_addr_t rd_addr,
  output reg_io_pkg::rd_rsp_t   rd_rsp,
  // Register contents.
  output reg_io_pkg::rw_bank_t  rw_regs,
  output reg_io_pkg::wo_bank_t  wo_regs,
  input  reg_io_pkg::ro_bank_t  ro_regs
);

  // First word index of each group.
  localparam int WO_FIRST = reg_io_pkg::NUM_RW_REGS;
  localparam int RO_FIRST = WO_FIRST + reg_io_pkg::NUM_WO_REGS;
  localparam int NUM_REGS = RO_FIRST + reg_io_pkg::NUM_RO_REGS;
  localparam int IDX_W    = $clog2(NUM_REGS);

  typedef logic [IDX_W-1:0] reg_idx_t;

  // Decoded address.
  typedef struct packed {
    logic     hit;
    reg_idx_t idx;
  } reg_sel_t;

  reg_sel_t wr_sel;
  reg_sel_t rd_sel;

  //*******************************************************************
  // Helpers
  //*******************************************************************

  // Word index is the byte offset from BASEADDR over four.
  // Anything outside the window, or past the last word, is a miss.
  function automatic reg_sel_t decode(reg_io_pkg::axi_addr_t addr);
    reg_io_pkg::axi_addr_t offset;
    reg_sel_t              sel;
    offset  = addr - BASEADDR;
    sel.hit = (addr >= BASEADDR) && (addr <= HIGHADDR) && ((offset >> 2) < NUM_REGS);
    sel.idx = offset[IDX_W+1:2];
    return sel;
  endfunction

  // Byte merge under the strobe.
  // Full word replace when strobes are not used.
  function automatic reg_io_pkg::reg_word_t merge(reg_io_pkg::reg_word_t  old_word,
                                                  reg_io_pkg::reg_word_t  new_word,
                                                  reg_io_pkg::byte_strb_t strb);
    reg_io_pkg::reg_word_t result;
    result = old_word;
    for (int b = 0; b < $bits(reg_io_pkg::byte_strb_t); b++) begin
      if (!USE_WSTRB || strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign wr_sel = decode(wr_req.addr);
  assign rd_sel = decode(rd_addr);

  //*******************************************************************
  // Storage
  //*******************************************************************

  // Read-only indices fall through both loops and change nothing.
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      rw_regs <= '0;
      wo_regs <= '0;
    end else if (wr_en && wr_sel.hit) begin
      for (int i = 0; i < reg_io_pkg::NUM_RW_REGS; i++) begin
        if (wr_sel.idx == i) begin
          rw_regs[i] <= merge(rw_regs[i], wr_req.data, wr_req.strb);
        end
      end
      for (int i = 0; i < reg_io_pkg::NUM_WO_REGS; i++) begin
        if (wr_sel.idx == WO_FIRST + i) begin
          wo_regs[i] <= merge(wo_regs[i], wr_req.data, wr_req.strb);
        end
      end
    end
  end

  //*******************************************************************
  // Responses
  //*******************************************************************

  always_comb begin
    if (!wr_sel.hit) begin
      wr_resp = reg_io_pkg::RESP_DECERR;
    end else if (wr_sel.idx >= RO_FIRST) begin
      wr_resp = reg_io_pkg::RESP_SLVERR;
    end else begin
      wr_resp = reg_io_pkg::RESP_OKAY;
    end
  end

  // Write-only words read back as zero with OKAY.
  always_comb begin
    rd_rsp.data = '0;
    rd_rsp.resp = reg_io_pkg::RESP_OKAY;
    if (!rd_sel.hit) begin
      rd_rsp.resp = reg_io_pkg::RESP_DECERR;
    end else begin
      for (int i = 0; i < reg_io_pkg::NUM_RW_REGS; i++) begin
        if (rd_sel.idx == i) begin
          rd_rsp.data = rw_regs[i];
        end
      end
      for (int i = 0; i < reg_io_pkg::NUM_RO_REGS; i++) begin
        if (rd_sel.idx == RO_FIRST + i) begin
          rd_rsp.data = ro_regs[i];
        end
      end
    end
  end

endmodule

/* design/reg_io_pkg.sv */
//*********************************************************************
// Shared types and constants for the AXI-Lite register I/O block.
//*********************************************************************
package reg_io_pkg;

  //*******************************************************************
  // Bus widths
  //*******************************************************************

  // Byte address as seen on the AXI-Lite port.
  typedef logic [31:0] axi_addr_t;

  // One register word, also the bus data width.
  typedef logic [31:0] reg_word_t;

  // One enable per data byte.
  typedef logic [3:0] byte_strb_t;

  // AXI response code.
  typedef logic [1:0] axi_resp_t;

  // Response codes used by this slave.
  // EXOKAY is never returned.
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  //*******************************************************************
  // Register map
  //*******************************************************************

  // Read/write words come first, then write-only, then read-only.
  localparam int NUM_RW_REGS = 2;
  localparam int NUM_WO_REGS = 2;
  localparam int NUM_RO_REGS = 4;

  // Register groups as flat packed arrays.
  // Element 0 sits in the low word.
  typedef reg_word_t [NUM_RW_REGS-1:0] rw_bank_t;
  typedef reg_word_t [NUM_WO_REGS-1:0] wo_bank_t;
  typedef reg_word_t [NUM_RO_REGS-1:0] ro_bank_t;

  //*******************************************************************
  // Channel payloads
  //*******************************************************************

  // One joined write, address plus data plus byte enables.
  typedef struct packed {
    axi_addr_t  addr;
    reg_word_t  data;
    byte_strb_t strb;
  } wr_req_t;

  // Read answer from the bank.
  typedef struct packed {
    reg_word_t data;
    axi_resp_t resp;
  } rd_rsp_t;

endpackage

/* design/reg_io_top.sv */
//*********************************************************************
// Register I/O top with AXI-Lite slave and read-only loopback.
//*********************************************************************
`timescale 1ns/10ps

module reg_io_top #(
  parameter bit                    USE_WSTRB = 1'b0,
  parameter reg_io_pkg::axi_addr_t BASEADDR  = 32'hFFFF_FFFF,
  parameter reg_io_pkg::axi_addr_t HIGHADDR  = 32'h0000_0000
) (
  input  logic                   s_axi_aclk,
  input  logic                   rst_n,
  // Write address and data.
  input  reg_io_pkg::axi_addr_t  s_axi_awaddr,
  input  logic                   s_axi_awvalid,
  output logic                   s_axi_awready,
  input  reg_io_pkg::reg_word_t  s_axi_wdata,
  input  reg_io_pkg::byte_strb_t s_axi_wstrb,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,
  // Write response.
  input  logic                   s_axi_bready,
  output logic                   s_axi_bvalid,
  output reg_io_pkg::axi_resp_t  s_axi_bresp,
  // Read address and data.
  input  reg_io_pkg::axi_addr_t  s_axi_araddr,
  input  logic                   s_axi_arvalid,
  output logic                   s_axi_arready,
  input  logic                   s_axi_rready,
  output logic                   s_axi_rvalid,
  output reg_io_pkg::reg_word_t  s_axi_rdata,
  output reg_io_pkg::axi_resp_t  s_axi_rresp
);

  // Channel to bank links.
  logic                  wr_en;
  reg_io_pkg::wr_req_t   wr_req;
  reg_io_pkg::axi_resp_t wr_resp;
  reg_io_pkg::axi_addr_t rd_addr;
  reg_io_pkg::rd_rsp_t   rd_rsp;

  // Register contents.
  reg_io_pkg::rw_bank_t rw_regs;
  reg_io_pkg::wo_bank_t wo_regs;
  reg_io_pkg::ro_bank_t ro_regs;

  axil_write_channel u_write (
    .s_axi_aclk    (s_axi_aclk),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bready  (s_axi_bready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bresp   (s_axi_bresp),
    .wr_en         (wr_en),
    .wr_req        (wr_req),
    .wr_resp       (wr_resp)
  );

  reg_bank #(
    .USE_WSTRB (USE_WSTRB),
    .BASEADDR  (BASEADDR),
    .HIGHADDR  (HIGHADDR)
  ) u_bank (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_req     (wr_req),
    .wr_resp    (wr_resp),
    .rd_addr    (rd_addr),
    .rd_rsp     (rd_rsp),
    .rw_regs    (rw_regs),
    .wo_regs    (wo_regs),
    .ro_regs    (ro_regs)
  );

  axil_read_channel u_read (
    .s_axi_aclk    (s_axi_aclk),
    .rst_n         (rst_n),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rready  (s_axi_rready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .rd_addr       (rd_addr),
    .rd_rsp        (rd_rsp)
  );

  // Read-only words mirror the writable ones.
  // Words 4 and 5 show rw 0 and 1, words 6 and 7 show wo 0 and 1.
  assign ro_regs = {wo_regs, rw_regs};

endmodule

/* sources.f */
+incdir+verification
design/reg_io_pkg.sv
design/axil_write_channel.sv
design/reg_bank.sv
design/axil_read_channel.sv
design/reg_io_top.sv
verification/tb_reg_io.sv

/* verification/tb_reg_io_tests.svh */
//*********************************************************************
// Bus tasks, reference model and directed tests for the register block.
//*********************************************************************

  // Model words 4 to 7 mirror words 0 to 3.
  reg_io_pkg::reg_word_t model_regs [8];

  function automatic reg_io_pkg::axi_addr_t reg_addr(input int idx);
    return BASEADDR + 4 * idx;
  endfunction

  // Applies a write to the model and gives the expected response.
  function automatic reg_io_pkg::axi_resp_t model_write(input reg_io_pkg::axi_addr_t addr,
      input reg_io_pkg::reg_word_t data, input reg_io_pkg::byte_strb_t strb);
    int idx;
    if (addr < BASEADDR || addr > HIGHADDR) begin
      return reg_io_pkg::RESP_DECERR;
    end
    idx = (addr - BASEADDR) >> 2;
    // Read-only words refuse writes.
    if (idx >= 4) begin
      return reg_io_pkg::RESP_SLVERR;
    end
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_regs[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    model_regs[idx + 4] = model_regs[idx];
    return reg_io_pkg::RESP_OKAY;
  endfunction

  // Write-only words and misses read as zero.
  function automatic reg_io_pkg::rd_rsp_t model_read(input reg_io_pkg::axi_addr_t addr);
    reg_io_pkg::rd_rsp_t rsp;
    int                  idx;
    rsp.data = '0;
    rsp.resp = reg_io_pkg::RESP_DECERR;
    if (addr >= BASEADDR && addr <= HIGHADDR) begin
      idx      = (addr - BASEADDR) >> 2;
      rsp.resp = reg_io_pkg::RESP_OKAY;
      rsp.data = (idx == 2 || idx == 3) ? '0 : model_regs[idx];
    end
    return rsp;
  endfunction

  //*******************************************************************
  // Bus tasks
  //*******************************************************************

  // Outputs are sampled on the falling edge, inputs change on the rising edge.
  task automatic axil_write(input reg_io_pkg::axi_addr_t addr, input reg_io_pkg::reg_word_t data,
      input reg_io_pkg::byte_strb_t strb, input int delay, output reg_io_pkg::axi_resp_t resp);
    @(posedge s_axi_aclk);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    @(negedge s_axi_aclk);
    while (!s_axi_awready) @(negedge s_axi_aclk);
    check_equal("wready with awready", 1, s_axi_wready);
    @(posedge s_axi_aclk);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    @(negedge s_axi_aclk);
    while (!s_axi_bvalid) @(negedge s_axi_aclk);
    resp = s_axi_bresp;
    // Response must hold while bready stays low.
    repeat (delay) begin
      @(negedge s_axi_aclk);
      check_equal("bvalid held", 1, s_axi_bvalid);
      check_equal("bresp held", resp, s_axi_bresp);
    end
    @(posedge s_axi_aclk);
    s_axi_bready <= 1'b1;
    @(negedge s_axi_aclk);
    check_equal("bvalid at handshake", 1, s_axi_bvalid);
    @(posedge s_axi_aclk);
    s_axi_bready <= 1'b0;
  endtask

  task automatic axil_read(input reg_io_pkg::axi_addr_t addr, input int delay,
      output reg_io_pkg::reg_word_t data, output reg_io_pkg::axi_resp_t resp);
    @(posedge s_axi_aclk);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    @(negedge s_axi_aclk);
    while (!s_axi_arready) @(negedge s_axi_aclk);
    @(posedge s_axi_aclk);
    s_axi_arvalid <= 1'b0;
    @(negedge s_axi_aclk);
    while (!s_axi_rvalid) @(negedge s_axi_aclk);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    repeat (delay) begin
      @(negedge s_axi_aclk);
      check_equal("rvalid held", 1, s_axi_rvalid);
      check_equal("rdata held", data, s_axi_rdata);
      check_equal("rresp held", resp, s_axi_rresp);
    end
    @(posedge s_axi_aclk);
    s_axi_rready <= 1'b1;
    @(negedge s_axi_aclk);
    check_equal("rvalid at handshake", 1, s_axi_rvalid);
    @(posedge s_axi_aclk);
    s_axi_rready <= 1'b0;
  endtask

  task automatic write_check(input reg_io_pkg::axi_addr_t addr, input reg_io_pkg::reg_word_t data,
      input reg_io_pkg::byte_strb_t strb, input int delay);
    reg_io_pkg::axi_resp_t expected;
    reg_io_pkg::axi_resp_t resp;
    expected = model_write(addr, data, strb);
    axil_write(addr, data, strb, delay, resp);
    check_equal($sformatf("bresp at %h", addr), expected, resp);
  endtask

  task automatic read_check(input reg_io_pkg::axi_addr_t addr, input int delay);
    reg_io_pkg::rd_rsp_t   expected;
    reg_io_pkg::reg_word_t data;
    reg_io_pkg::axi_resp_t resp;
    expected = model_read(addr);
    axil_read(addr, delay, data, resp);
    check_equal($sformatf("rdata at %h", addr), expected.data, data);
    check_equal($sformatf("rresp at %h", addr), expected.resp, resp);
  endtask

  //*******************************************************************
  // Directed tests
  //*******************************************************************

  // Holds reset, checks idle outputs, then reads every word.
  task automatic test_reset();
    cur_test = "reset";
    for (int i = 0; i < 8; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) begin
      @(negedge s_axi_aclk);
      check_equal("handshake outputs", 0,
                  {s_axi_awready, s_axi_wready, s_axi_arready, s_axi_bvalid, s_axi_rvalid});
    end
    @(posedge s_axi_aclk);
    rst_n <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      read_check(reg_addr(i), 0);
    end
  endtask

  task automatic test_rw_loopback();
    cur_test = "rw_loopback";
    for (int i = 0; i < 2; i++) begin
      write_check(reg_addr(i), lcg_next(), 4'hF, 0);
    end
    for (int i = 0; i < 2; i++) begin
      read_check(reg_addr(i), 0);
      read_check(reg_addr(i + 4), 0);
    end
  endtask

  task automatic test_write_only();
    cur_test = "write_only";
    for (int i = 2; i < 4; i++) begin
      write_check(reg_addr(i), lcg_next(), 4'hF, 0);
    end
    for (int i = 2; i < 4; i++) begin
      read_check(reg_addr(i), 0);
      read_check(reg_addr(i + 4), 0);
    end
  endtask

  // Single-byte and mixed strobes on rw word 0, then on wo word 3.
  task automatic test_byte_strobes();
    reg_io_pkg::byte_strb_t strobes [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h6, 4'h9, 4'h3, 4'hC};
    int                     target;
    cur_test = "byte_strobes";
    for (int s = 0; s < 8; s++) begin
      target = (s < 6) ? 0 : 3;
      write_check(reg_addr(target), lcg_next(), strobes[s], 0);
      read_check(reg_addr(target), 0);
      read_check(reg_addr(target + 4), 0);
    end
  endtask

  task automatic test_error_responses();
    cur_test = "error_responses";
    write_check(reg_addr(5), lcg_next(), 4'hF, 0);
    read_check(reg_addr(5), 0);
    // Just past the window and just below it.
    write_check(32'h4000_0020, lcg_next(), 4'hF, 0);
    read_check(32'h4000_0020, 0);
    write_check(32'h3FFF_FFFC, lcg_next(), 4'hF, 0);
    read_check(32'h3FFF_FFFC, 0);
    for (int i = 0; i < 8; i++) begin
      read_check(reg_addr(i), 0);
    end
  endtask

  // Delays of 0 to 7 cycles from the top bits of the generator.
  task automatic test_back_pressure();
    cur_test = "back_pressure";
    for (int i = 0; i < 4; i++) begin
      write_check(reg_addr(i), lcg_next(), 4'hF, lcg_next() >> 29);
    end
    read_check(reg_addr(0), lcg_next() >> 29);
    read_check(reg_addr(1), lcg_next() >> 29);
    read_check(reg_addr(6), lcg_next() >> 29);
    read_check(reg_addr(7), lcg_next() >> 29);
  endtask

/* verification/tb_reg_io.sv */
//*********************************************************************
// Testbench for the AXI-Lite register I/O block.
//*********************************************************************
`timescale 1ns/10ps

module tb_reg_io;

  localparam reg_io_pkg::axi_addr_t BASEADDR = 32'h4000_0000;
  localparam reg_io_pkg::axi_addr_t HIGHADDR = 32'h4000_001F;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;

  // Upper bound on bus transfers issued by all tests.
  localparam int NUM_TRANSFERS   = 66;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * NUM_TRANSFERS + 200;

  //*******************************************************************
  // DUT signals
  //*******************************************************************

  logic                   s_axi_aclk;
  logic                   rst_n;
  reg_io_pkg::axi_addr_t  s_axi_awaddr;
  logic                   s_axi_awvalid;
  logic                   s_axi_awready;
  reg_io_pkg::reg_word_t  s_axi_wdata;
  reg_io_pkg::byte_strb_t s_axi_wstrb;
  logic                   s_axi_wvalid;
  logic                   s_axi_wready;
  logic                   s_axi_bready;
  logic                   s_axi_bvalid;
  reg_io_pkg::axi_resp_t  s_axi_bresp;
  reg_io_pkg::axi_addr_t  s_axi_araddr;
  logic                   s_axi_arvalid;
  logic                   s_axi_arready;
  logic                   s_axi_rready;
  logic                   s_axi_rvalid;
  reg_io_pkg::reg_word_t  s_axi_rdata;
  reg_io_pkg::axi_resp_t  s_axi_rresp;

  // Name of the running test, shown on error lines.
  string cur_test = "setup";
  logic [31:0] lcg_state = 32'hdba6_32dd;

  reg_io_top #(
    .USE_WSTRB (1'b1),
    .BASEADDR  (BASEADDR),
    .HIGHADDR  (HIGHADDR)
  ) DUT (.*);

  // 4 ns clock.
  always #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;

  //*******************************************************************
  // Support
  //*******************************************************************

  // Linear congruential generator for data and delays.
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s expected %h actual %h", cur_test, what, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  `include "tb_reg_io_tests.svh"

  // Watchdog sized from the transfer count.
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the bus transfers did not complete in time");
    $display("test failed");
    $fatal(1, "timeout");
  end

  //*******************************************************************
  // Test sequence
  //*******************************************************************

  initial begin
    s_axi_aclk    = 1'b0;
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    test_reset();
    test_rw_loopback();
    test_write_only();
    test_byte_strobes();
    test_error_responses();
    test_back_pressure();
    $display("test passed");
    $finish;
  end

endmodule
